// File: hdl/pe_pkg.sv
`default_nettype none

package pe_pkg;

    // block geometry
    localparam int DATA_W    = 16;
    localparam int BLOCK_LEN = 8;
    localparam int ADDR_W    = 3;

    // final buffer index, used by every address walker
    localparam logic [ADDR_W-1:0] LAST_IDX = ADDR_W'(BLOCK_LEN - 1);

    // word operations applied during the compute pass
    typedef enum logic [2:0] {
        OP_PASS = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        OP_XOR  = 3'd4
    } pe_op_e;

    // load, compute and drain never overlap
    typedef enum logic [1:0] {
        PH_LOAD    = 2'd0,
        PH_COMPUTE = 2'd1,
        PH_DRAIN   = 2'd2
    } pe_phase_e;

    typedef struct packed {
        pe_op_e              op;
        logic [DATA_W-1:0]   operand;
    } pe_cfg_t;

    typedef struct packed {
        logic                en;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } mem_wr_t;

    typedef struct packed {
        logic                en;
        logic [ADDR_W-1:0]   addr;
    } mem_rd_t;

endpackage

`default_nettype wire

// File: hdl/agu.sv
`timescale 1ns/1ns
`default_nettype none

module agu #(
    parameter int W = 3
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  logic         start,
    input  logic [W-1:0] fin,
    output logic [W-1:0] data,
    output logic         last
);

    // start wins over en so a walker can rewind on its final step
    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end
        else if (start) begin
            data <= '0;
        end
        else if (en && !last) begin
            data <= data + 1'b1;
        end
    end

    // held at fin until the next start
    always_comb begin
        last = (data == fin);
    end

endmodule

`default_nettype wire

// File: hdl/local_mem.sv
`timescale 1ns/1ns
`default_nettype none

module local_mem (
    input  logic                        clk,
    input  pe_pkg::mem_wr_t             wr,
    input  pe_pkg::mem_rd_t             rd,
    output logic [pe_pkg::DATA_W-1:0]   rd_data
);

    logic [pe_pkg::DATA_W-1:0] mem [pe_pkg::BLOCK_LEN];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // output register only loads on a request, drain stalls keep it stable
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/src_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module src_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_en,
    input  logic                        src_valid,
    output logic                        src_ready,
    input  logic [pe_pkg::DATA_W-1:0]   src_data,
    input  logic                        src_last,
    output logic                        src_fire,
    output pe_pkg::mem_wr_t             wr,
    output logic                        load_done,
    output logic                        frame_err
);

    logic [pe_pkg::ADDR_W-1:0] idx;
    logic                      idx_last;

    always_comb begin
        src_ready = load_en;
        src_fire  = src_valid & load_en;
    end

    // rewinds on the final word so the next block starts at zero
    agu #(.W(pe_pkg::ADDR_W)) u_agu (
        .clk   (clk),
        .rst   (rst),
        .en    (src_fire),
        .start (src_fire & idx_last),
        .fin   (pe_pkg::LAST_IDX),
        .data  (idx),
        .last  (idx_last)
    );

    // word goes straight into the buffer on the accepting edge
    always_comb begin
        wr.en     = src_fire;
        wr.addr   = idx;
        wr.data   = src_data;
        load_done = src_fire & idx_last;
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_err <= 1'b0;
        end
        else if (src_fire && (src_last != idx_last)) begin
            frame_err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu_stage.sv
`timescale 1ns/1ns
`default_nettype none

module alu_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  pe_pkg::pe_cfg_t             cfg,
    output pe_pkg::mem_rd_t             rd,
    input  logic [pe_pkg::DATA_W-1:0]   rd_data,
    output pe_pkg::mem_wr_t             wr,
    output logic                        done
);

    logic                        active;
    logic [pe_pkg::ADDR_W-1:0]   idx;
    logic                        idx_last;
    logic                        rd_v1;
    logic                        rd_last1;
    logic [pe_pkg::ADDR_W-1:0]   rd_a1;
    logic [pe_pkg::DATA_W-1:0]   result;
    logic                        wr_en;
    logic [pe_pkg::ADDR_W-1:0]   wr_addr;
    logic [pe_pkg::DATA_W-1:0]   wr_data;

    agu #(.W(pe_pkg::ADDR_W)) u_agu (
        .clk   (clk),
        .rst   (rst),
        .en    (active),
        .start (start),
        .fin   (pe_pkg::LAST_IDX),
        .data  (idx),
        .last  (idx_last)
    );

    // one read per cycle for the whole block
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end
        else if (start) begin
            active <= 1'b1;
        end
        else if (active && idx_last) begin
            active <= 1'b0;
        end
    end

    always_comb begin
        rd.en   = active;
        rd.addr = idx;
    end

    // multiply keeps the low half of the product
    always_comb begin
        case (cfg.op)
            pe_pkg::OP_ADD: result = rd_data + cfg.operand;
            pe_pkg::OP_SUB: result = rd_data - cfg.operand;
            pe_pkg::OP_MUL: result = rd_data * cfg.operand;
            pe_pkg::OP_XOR: result = rd_data ^ cfg.operand;
            default:        result = rd_data;
        endcase
    end

    // stage 1 lines up with the read data, stage 2 holds the result
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_v1    <= 1'b0;
            rd_last1 <= 1'b0;
            wr_en    <= 1'b0;
            done     <= 1'b0;
        end
        else begin
            rd_v1    <= active;
            rd_last1 <= active & idx_last;
            wr_en    <= rd_v1;
            done     <= rd_last1;
        end
    end

    always_ff @(posedge clk) begin
        rd_a1   <= idx;
        wr_addr <= rd_a1;
        wr_data <= result;
    end

    // written back in place
    always_comb begin
        wr.en   = wr_en;
        wr.addr = wr_addr;
        wr.data = wr_data;
    end

endmodule

`default_nettype wire

// File: hdl/dst_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dst_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        dst_ready,
    output pe_pkg::mem_rd_t             rd,
    input  logic [pe_pkg::DATA_W-1:0]   rd_data,
    output logic                        dst_valid,
    output logic [pe_pkg::DATA_W-1:0]   dst_data,
    output logic                        dst_last,
    output logic                        done
);

    logic                      stream_active;
    logic [pe_pkg::ADDR_W-1:0] i;
    logic                      last_i;

    // dst_ready is the enable of the whole drain pipeline
    agu #(.W(pe_pkg::ADDR_W)) u_agu (
        .clk   (clk),
        .rst   (rst),
        .en    (stream_active & dst_ready),
        .start (start),
        .fin   (pe_pkg::LAST_IDX),
        .data  (i),
        .last  (last_i)
    );

    // raised by start, dropped once the last index has been requested
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end
        else if (start) begin
            stream_active <= 1'b1;
        end
        else if (dst_ready && last_i) begin
            stream_active <= 1'b0;
        end
    end

    always_comb begin
        rd.en   = stream_active & dst_ready;
        rd.addr = i;
    end

    // valid and last follow the read by one enabled cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end
        else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & last_i;
        end
    end

    // read register holds under stalls, so data needs no extra stage
    always_comb begin
        dst_data = rd_data;
        done     = dst_valid & dst_last & dst_ready;
    end

endmodule

`default_nettype wire

// File: hdl/pe_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module pe_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  pe_pkg::pe_cfg_t     cfg_in,
    input  logic                src_fire,
    input  logic                load_done,
    input  logic                cmp_done,
    input  logic                drain_done,
    output logic                load_en,
    output logic                cmp_start,
    output logic                drain_start,
    output pe_pkg::pe_cfg_t     cfg,
    input  pe_pkg::mem_wr_t     src_wr,
    input  pe_pkg::mem_wr_t     cmp_wr,
    input  pe_pkg::mem_rd_t     cmp_rd,
    input  pe_pkg::mem_rd_t     dst_rd,
    output pe_pkg::mem_wr_t     mem_wr,
    output pe_pkg::mem_rd_t     mem_rd
);

    pe_pkg::pe_phase_e phase;
    pe_pkg::pe_phase_e phase_nxt;
    logic              first_word;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            pe_pkg::PH_LOAD:    if (load_done)  phase_nxt = pe_pkg::PH_COMPUTE;
            pe_pkg::PH_COMPUTE: if (cmp_done)   phase_nxt = pe_pkg::PH_DRAIN;
            pe_pkg::PH_DRAIN:   if (drain_done) phase_nxt = pe_pkg::PH_LOAD;
            default:            phase_nxt = pe_pkg::PH_LOAD;
        endcase
    end

    // start pulses land on the first cycle of the new phase
    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= pe_pkg::PH_LOAD;
            cmp_start   <= 1'b0;
            drain_start <= 1'b0;
        end
        else begin
            phase       <= phase_nxt;
            cmp_start   <= (phase == pe_pkg::PH_LOAD) && load_done;
            drain_start <= (phase == pe_pkg::PH_COMPUTE) && cmp_done;
        end
    end

    // armed again by the final word of each block
    always_ff @(posedge clk) begin
        if (rst) begin
            first_word <= 1'b1;
        end
        else if (load_done) begin
            first_word <= 1'b1;
        end
        else if (src_fire) begin
            first_word <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (src_fire && first_word) begin
            cfg <= cfg_in;
        end
    end

    always_comb begin
        load_en = (phase == pe_pkg::PH_LOAD);
    end

    // one owner per buffer port in each phase
    always_comb begin
        mem_wr = '0;
        mem_rd = '0;
        case (phase)
            pe_pkg::PH_LOAD: begin
                mem_wr = src_wr;
            end
            pe_pkg::PH_COMPUTE: begin
                mem_wr = cmp_wr;
                mem_rd = cmp_rd;
            end
            pe_pkg::PH_DRAIN: begin
                mem_rd = dst_rd;
            end
            default: begin
                mem_wr = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/stream_pe_top.sv
`timescale 1ns/1ns
`default_nettype none

module stream_pe_top (
    input  logic                        clk,
    input  logic                        rst,
    input  pe_pkg::pe_cfg_t             cfg,
    input  logic                        src_valid,
    output logic                        src_ready,
    input  logic [pe_pkg::DATA_W-1:0]   src_data,
    input  logic                        src_last,
    output logic                        dst_valid,
    input  logic                        dst_ready,
    output logic [pe_pkg::DATA_W-1:0]   dst_data,
    output logic                        dst_last,
    output logic                        frame_err
);

    logic                      src_fire;
    logic                      load_en;
    logic                      load_done;
    logic                      cmp_start;
    logic                      cmp_done;
    logic                      drain_start;
    logic                      drain_done;
    pe_pkg::pe_cfg_t           cfg_q;
    pe_pkg::mem_wr_t           src_wr;
    pe_pkg::mem_wr_t           cmp_wr;
    pe_pkg::mem_rd_t           cmp_rd;
    pe_pkg::mem_rd_t           dst_rd;
    pe_pkg::mem_wr_t           mem_wr;
    pe_pkg::mem_rd_t           mem_rd;
    logic [pe_pkg::DATA_W-1:0] rd_data;

    pe_ctrl u_pe_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cfg_in      (cfg),
        .src_fire    (src_fire),
        .load_done   (load_done),
        .cmp_done    (cmp_done),
        .drain_done  (drain_done),
        .load_en     (load_en),
        .cmp_start   (cmp_start),
        .drain_start (drain_start),
        .cfg         (cfg_q),
        .src_wr      (src_wr),
        .cmp_wr      (cmp_wr),
        .cmp_rd      (cmp_rd),
        .dst_rd      (dst_rd),
        .mem_wr      (mem_wr),
        .mem_rd      (mem_rd)
    );

    src_ctrl u_src_ctrl (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src_data  (src_data),
        .src_last  (src_last),
        .src_fire  (src_fire),
        .wr        (src_wr),
        .load_done (load_done),
        .frame_err (frame_err)
    );

    alu_stage u_alu_stage (
        .clk     (clk),
        .rst     (rst),
        .start   (cmp_start),
        .cfg     (cfg_q),
        .rd      (cmp_rd),
        .rd_data (rd_data),
        .wr      (cmp_wr),
        .done    (cmp_done)
    );

    dst_ctrl u_dst_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (drain_start),
        .dst_ready (dst_ready),
        .rd        (dst_rd),
        .rd_data   (rd_data),
        .dst_valid (dst_valid),
        .dst_data  (dst_data),
        .dst_last  (dst_last),
        .done      (drain_done)
    );

    local_mem u_local_mem (
        .clk     (clk),
        .wr      (mem_wr),
        .rd      (mem_rd),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_stream_pe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_stream_pe;

    localparam int WAIT_LIMIT = 2000;

    logic                      clk = 1'b0;
    logic                      rst;
    pe_pkg::pe_cfg_t           cfg;
    logic                      src_valid;
    logic                      src_ready;
    logic [pe_pkg::DATA_W-1:0] src_data;
    logic                      src_last;
    logic                      dst_valid;
    logic                      dst_ready = 1'b1;
    logic [pe_pkg::DATA_W-1:0] dst_data;
    logic                      dst_last;
    logic                      frame_err;

    integer                    seed;
    integer                    rdy_seed;
    logic [31:0]               rdy_rnd;
    logic                      stall_en;
    int                        errors;
    int                        timeouts;
    int                        sent;
    int                        blocks_done;

    // monitor state
    logic [pe_pkg::DATA_W-1:0] exp_q [$];
    pe_pkg::pe_cfg_t           blk_cfg;
    int                        in_cnt;
    int                        out_cnt;
    logic                      loaded;
    logic                      stalled;
    logic [pe_pkg::DATA_W-1:0] held_data;
    logic                      err_prev;
    pe_pkg::pe_op_e            op_list [5];

    stream_pe_top u_stream_pe_top (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src_data  (src_data),
        .src_last  (src_last),
        .dst_valid (dst_valid),
        .dst_ready (dst_ready),
        .dst_data  (dst_data),
        .dst_last  (dst_last),
        .frame_err (frame_err)
    );

    always #4 clk = ~clk;

    // expected word from the opcode rules
    function automatic logic [pe_pkg::DATA_W-1:0] ref_op(
        input pe_pkg::pe_cfg_t           c,
        input logic [pe_pkg::DATA_W-1:0] x
    );
        logic [pe_pkg::DATA_W-1:0] y;
        case (c.op)
            pe_pkg::OP_ADD: y = x + c.operand;
            pe_pkg::OP_SUB: y = x - c.operand;
            // 16-bit context keeps the low half of the product
            pe_pkg::OP_MUL: y = x * c.operand;
            pe_pkg::OP_XOR: y = x ^ c.operand;
            default:        y = x;
        endcase
        return y;
    endfunction

    task automatic check_val(input string name, input logic [pe_pkg::DATA_W-1:0] exp,
                             input logic [pe_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic end_sim();
        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic wait_blocks(input int n);
        int cyc;
        cyc = 0;
        while (blocks_done < n) begin
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                $display("timeout: only %0d of %0d blocks came out", blocks_done, n);
                timeouts++;
                end_sim();
            end
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_err_flag();
        int cyc;
        cyc = 0;
        while (frame_err !== 1'b1) begin
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                $display("timeout: frame_err never rose after a misplaced src_last");
                timeouts++;
                end_sim();
            end
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // bad_last and cfg_swap are word indices, -1 means unused
    task automatic send_block(input int gaps, input int bad_last, input int cfg_swap);
        logic [31:0] rnd;
        int          cyc;
        int          last_at;
        last_at = (bad_last >= 0) ? bad_last : pe_pkg::BLOCK_LEN - 1;
        for (int w = 0; w < pe_pkg::BLOCK_LEN; w++) begin
            if (gaps != 0) begin
                rnd = $random(seed);
                repeat (rnd[1:0]) begin
                    src_valid = 1'b0;
                    @(posedge clk);
                    #1;
                end
            end
            if (w == cfg_swap) begin
                cfg.operand = ~cfg.operand;
                cfg.op      = (cfg.op == pe_pkg::OP_ADD) ? pe_pkg::OP_SUB : pe_pkg::OP_ADD;
            end
            rnd       = $random(seed);
            src_valid = 1'b1;
            src_data  = rnd[pe_pkg::DATA_W-1:0];
            src_last  = (w == last_at);
            cyc = 0;
            @(negedge clk);
            while (!src_ready) begin
                cyc++;
                if (cyc > WAIT_LIMIT) begin
                    $display("timeout: source word %0d of block %0d never accepted", w, sent);
                    timeouts++;
                    end_sim();
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        src_valid = 1'b0;
        src_last  = 1'b0;
        sent++;
    endtask

    // dst_ready driven 1 ns after the edge
    always @(posedge clk) begin
        #1;
        rdy_rnd = $random(rdy_seed);
        if (stall_en) begin
            dst_ready = (rdy_rnd[1:0] != 2'b00);
        end
        else begin
            dst_ready = 1'b1;
        end
    end

    // sampled at the falling edge, where every signal is settled
    always @(negedge clk) begin
        if (rst) begin
            in_cnt   = 0;
            out_cnt  = 0;
            loaded   = 1'b0;
            stalled  = 1'b0;
            err_prev = 1'b0;
        end
        else begin
            if (loaded && src_ready) begin
                errors++;
                $display("time %0t: src_ready is high while a block is still in the PE", $time);
            end
            if (src_valid && src_ready) begin
                // cfg counts from the first word of each block
                if (in_cnt == 0) begin
                    blk_cfg = cfg;
                end
                exp_q.push_back(ref_op(blk_cfg, src_data));
                in_cnt++;
                if (in_cnt == pe_pkg::BLOCK_LEN) begin
                    in_cnt = 0;
                    loaded = 1'b1;
                end
            end
            if (stalled) begin
                check_val("dst_valid", 16'(1'b1), 16'(dst_valid));
                check_val("dst_data", held_data, dst_data);
            end
            stalled   = dst_valid && !dst_ready;
            held_data = dst_data;
            if (dst_valid && dst_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("time %0t: output word arrived with nothing expected", $time);
                end
                else begin
                    check_val("dst_data", exp_q.pop_front(), dst_data);
                end
                check_val("dst_last", 16'(out_cnt == pe_pkg::BLOCK_LEN - 1), 16'(dst_last));
                out_cnt++;
                if (out_cnt == pe_pkg::BLOCK_LEN) begin
                    out_cnt = 0;
                    loaded  = 1'b0;
                    blocks_done++;
                end
            end
            if (err_prev && !frame_err) begin
                errors++;
                $display("time %0t: frame_err dropped without a reset", $time);
            end
            err_prev = frame_err;
        end
    end

    initial begin
        seed        = 32'h99829a8f;
        rdy_seed    = 32'h99829a8f;
        errors      = 0;
        timeouts    = 0;
        sent        = 0;
        blocks_done = 0;
        stall_en    = 1'b0;
        rst         = 1'b1;
        cfg         = '0;
        src_valid   = 1'b0;
        src_data    = '0;
        src_last    = 1'b0;
        op_list[0]  = pe_pkg::OP_PASS;
        op_list[1]  = pe_pkg::OP_ADD;
        op_list[2]  = pe_pkg::OP_SUB;
        op_list[3]  = pe_pkg::OP_MUL;
        op_list[4]  = pe_pkg::OP_XOR;
        apply_reset();
        @(negedge clk);
        check_val("src_ready", 16'(1'b1), 16'(src_ready));
        check_val("dst_valid", 16'(1'b0), 16'(dst_valid));
        check_val("dst_last", 16'(1'b0), 16'(dst_last));
        check_val("frame_err", 16'(1'b0), 16'(frame_err));
        @(posedge clk);
        #1;

        // every opcode once, no stalls
        for (int k = 0; k < 5; k++) begin
            cfg.op      = op_list[k];
            cfg.operand = 16'h1234 + 16'(k * 16'h0f0f);
            send_block(0, -1, -1);
        end

        // back-pressure, then source gaps on top of it
        stall_en = 1'b1;
        cfg.op   = pe_pkg::OP_MUL;
        send_block(0, -1, -1);
        cfg.op   = pe_pkg::OP_ADD;
        send_block(0, -1, -1);
        cfg.op   = pe_pkg::OP_SUB;
        send_block(1, -1, -1);
        cfg.op   = pe_pkg::OP_XOR;
        send_block(1, -1, -1);

        // cfg moves under a block in flight
        cfg.op = pe_pkg::OP_MUL;
        send_block(1, -1, 3);
        wait_blocks(sent);
        check_val("frame_err", 16'(1'b0), 16'(frame_err));

        // misplaced last marker is sticky until reset
        send_block(0, 2, -1);
        wait_err_flag();
        wait_blocks(sent);
        send_block(1, -1, -1);
        wait_blocks(sent);
        check_val("frame_err", 16'(1'b1), 16'(frame_err));
        check_val("exp_q size", 16'(0), 16'(exp_q.size()));
        apply_reset();
        @(negedge clk);
        check_val("frame_err", 16'(1'b0), 16'(frame_err));
        check_val("src_ready", 16'(1'b1), 16'(src_ready));
        @(posedge clk);
        #1;
        cfg.op = pe_pkg::OP_ADD;
        send_block(1, -1, -1);
        wait_blocks(sent);
        check_val("exp_q size", 16'(0), 16'(exp_q.size()));
        end_sim();
    end

endmodule

`default_nettype wire

// File: src.f
hdl/pe_pkg.sv
hdl/agu.sv
hdl/local_mem.sv
hdl/src_ctrl.sv
hdl/alu_stage.sv
hdl/dst_ctrl.sv
hdl/pe_ctrl.sv
hdl/stream_pe_top.sv
bench/tb_stream_pe.sv

// File: run_sim.sh
#!/bin/sh
# build and run the stream PE testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns -f src.f \
    --top-module tb_stream_pe --Mdir obj_dir -o tb_stream_pe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_stream_pe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
